// File: Makefile
# Verilator build and run of the horizontal padding stage

VERILATOR ?= verilator
TOP       ?= tb_conv_pad
DUT_TOP   ?= conv_pad_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(DUT_TOP) \
		design/conv_cfg_pkg.sv design/conv_stream_pkg.sv design/pad_filter.sv \
		design/member_gate.sv design/member_shift.sv design/conv_pad_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/conv_cfg_pkg.sv
// sizing constants of the convolution engine
// kernel, stride and member counts plus the bit widths derived from them

package conv_cfg_pkg;

    // largest odd kernel width handled by the pad stage
    localparam int KW_MAX = 5;

    // half kernel width, also the depth of the column start/end registers
    localparam int KW2_MAX = KW_MAX / 2;

    // largest horizontal stride
    localparam int SW_MAX = 2;

    // parallel datapath words per beat
    localparam int MEMBERS = 8;

    // width of a single member word
    localparam int WORD_W = 8;

    // clr code holds left codes (odd) ORed with right codes (even)
    localparam int BITS_KW = $clog2(KW_MAX + 1);

    // kw2 must reach KW2_MAX
    localparam int BITS_KW2 = $clog2(KW2_MAX + 1);

    // sw_1 runs 0 .. SW_MAX-1
    localparam int BITS_SW = (SW_MAX > 1) ? $clog2(SW_MAX) : 1;

    // rotate amount and group index both address members
    localparam int BITS_MEMBERS = $clog2(MEMBERS);
    localparam int BITS_OUT_SHIFT = $clog2(MEMBERS);

endpackage

// File: design/conv_pad_top.sv
// conv_pad_top
// horizontal zero padding stage, pad control plus gate and rotate
// stages, two enabled cycles from beat_in to beat_out

`timescale 1ns/100ps

module conv_pad_top (
    input  logic                                  aclk,
    input  logic                                  aclken,
    input  logic                                  rst_n,
    input  conv_stream_pkg::member_beat_t         beat_in,
    output conv_stream_pkg::member_beat_t         beat_out,
    output logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] last_group
);

    conv_stream_pkg::pad_ctrl_t     pad_ctrl;
    conv_stream_pkg::member_beat_t  gated;

    // shift fields follow their beat into the second stage
    logic [conv_cfg_pkg::BITS_MEMBERS-1:0]   shift_a_q;
    logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] shift_b_q;

    pad_filter u_pad_filter (
        .aclk     (aclk),
        .aclken   (aclken),
        .rst_n    (rst_n),
        .user     (beat_in.user),
        .valid_in (beat_in.valid),
        .pad_ctrl (pad_ctrl)
    );

    member_gate u_member_gate (
        .aclk     (aclk),
        .aclken   (aclken),
        .rst_n    (rst_n),
        .beat_in  (beat_in),
        .pad_ctrl (pad_ctrl),
        .gated    (gated)
    );

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            shift_a_q <= '0;
            shift_b_q <= '0;
        end else if (aclken) begin
            shift_a_q <= pad_ctrl.shift_a;
            shift_b_q <= pad_ctrl.shift_b;
        end
    end

    member_shift u_member_shift (
        .aclk       (aclk),
        .aclken     (aclken),
        .rst_n      (rst_n),
        .gated      (gated),
        .shift_a    (shift_a_q),
        .shift_b    (shift_b_q),
        .beat_out   (beat_out),
        .last_group (last_group)
    );

endmodule

// File: design/conv_stream_pkg.sv
// stream level types of the pad stage
// user tag, member beat and the pad control bundle

package conv_stream_pkg;

    // tag that travels with every beat
    typedef struct packed {
        logic                                is_config;
        logic                                is_col_valid;
        logic                                is_cols_1_k2;  // third column from the end
        logic                                is_cin_last;
        logic [conv_cfg_pkg::BITS_KW2-1:0]   kw2;
        logic [conv_cfg_pkg::BITS_SW-1:0]    sw_1;
    } conv_user_t;

    // one beat of MEMBERS words
    typedef struct packed {
        logic                                                         valid;
        logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0]   data;
        conv_user_t                                                   user;
    } member_beat_t;

    // control from pad_filter to both datapath stages
    typedef struct packed {
        logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::BITS_KW-1:0]  clr;
        logic                                                         valid_mask;
        logic [conv_cfg_pkg::BITS_MEMBERS-1:0]                        shift_a;
        logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0]                      shift_b;
    } pad_ctrl_t;

endpackage

// File: design/member_gate.sv
// member_gate
// one register stage that drops masked beats and zeroes the
// members sitting on a padded edge

`timescale 1ns/100ps

module member_gate (
    input  logic                          aclk,
    input  logic                          aclken,
    input  logic                          rst_n,
    input  conv_stream_pkg::member_beat_t beat_in,
    input  conv_stream_pkg::pad_ctrl_t    pad_ctrl,
    output conv_stream_pkg::member_beat_t gated
);

    logic                                                       valid_q;
    logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] data_d;
    logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] data_q;
    conv_stream_pkg::conv_user_t                                user_q;

    // nonzero clr means padding, config words always pass
    always_comb begin
        for (int m = 0; m < conv_cfg_pkg::MEMBERS; m++) begin
            if (pad_ctrl.clr[m] != '0 && !beat_in.user.is_config)
                data_d[m] = '0;
            else
                data_d[m] = beat_in.data[m];
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n)
            valid_q <= 1'b0;
        else if (aclken)
            valid_q <= beat_in.valid && pad_ctrl.valid_mask;
    end

    // payload
    always_ff @(posedge aclk) begin
        if (aclken) begin
            data_q <= data_d;
            user_q <= beat_in.user;
        end
    end

    assign gated = '{valid: valid_q, data: data_q, user: user_q};

    // config beats are never dropped by the start column mask
    a_config_passes: assert property (@(posedge aclk) disable iff (!rst_n)
        aclken && beat_in.valid && beat_in.user.is_config |=> gated.valid);

endmodule

// File: design/member_shift.sv
// member_shift
// one register stage that rotates members toward index 0 by shift_a
// and latches the last useful member group from shift_b

`timescale 1ns/100ps

module member_shift (
    input  logic                                  aclk,
    input  logic                                  aclken,
    input  logic                                  rst_n,
    input  conv_stream_pkg::member_beat_t         gated,
    input  logic [conv_cfg_pkg::BITS_MEMBERS-1:0]   shift_a,
    input  logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] shift_b,
    output conv_stream_pkg::member_beat_t         beat_out,
    output logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] last_group
);

    logic                                                       valid_q;
    logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] rot_data;
    logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] data_q;
    conv_stream_pkg::conv_user_t                                user_q;

    // output member m takes input member m+shift_a, wrapping around
    always_comb begin
        for (int m = 0; m < conv_cfg_pkg::MEMBERS; m++)
            rot_data[m] = gated.data[(m + int'(shift_a)) % conv_cfg_pkg::MEMBERS];
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            valid_q    <= 1'b0;
            last_group <= '0;
        end else if (aclken) begin
            valid_q    <= gated.valid;
            last_group <= shift_b;
        end
    end

    always_ff @(posedge aclk) begin
        if (aclken) begin
            data_q <= rot_data;
            user_q <= gated.user;
        end
    end

    assign beat_out = '{valid: valid_q, data: data_q, user: user_q};

    // the aligned selector never asks for more than a half kernel
    a_shift_range: assert property (@(posedge aclk) disable iff (!rst_n)
        aclken |-> (int'(shift_a) <= conv_cfg_pkg::KW2_MAX));

endmodule

// File: design/pad_filter.sv
// pad_filter
// column start/end tracking for horizontal zero padding, per member
// center/left/right code, valid mask for the start columns and the
// two shift selectors for the rotate stage

`timescale 1ns/100ps

module pad_filter (
    input  logic                        aclk,
    input  logic                        aclken,
    input  logic                        rst_n,
    input  conv_stream_pkg::conv_user_t user,
    input  logic                        valid_in,
    output conv_stream_pkg::pad_ctrl_t  pad_ctrl
);

    // registers indexed from 1 so kw2 addresses them directly
    logic [conv_cfg_pkg::KW2_MAX:1] col_start;
    logic [conv_cfg_pkg::KW2_MAX:1] col_start_nxt;
    logic [conv_cfg_pkg::KW2_MAX:1] col_end;
    logic [conv_cfg_pkg::KW2_MAX:1] col_end_nxt;
    // bit 0 tied low, selected when kw2 is zero
    logic [conv_cfg_pkg::KW2_MAX:0] col_end_x;
    logic [conv_cfg_pkg::KW2_MAX:1] col_end_masked [conv_cfg_pkg::MEMBERS];

    logic                               beat_en;
    logic                               col_en;
    logic [conv_cfg_pkg::MEMBERS-1:0]   masked_en;

    // lookup tables, filled at elaboration
    logic [conv_cfg_pkg::BITS_KW-1:0]        left_lut  [0:conv_cfg_pkg::KW2_MAX][1:conv_cfg_pkg::KW2_MAX];
    logic [conv_cfg_pkg::BITS_KW-1:0]        right_lut [1:conv_cfg_pkg::KW2_MAX];
    logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] shift_b_lut [0:conv_cfg_pkg::KW2_MAX][0:conv_cfg_pkg::SW_MAX-1];

    logic [conv_cfg_pkg::BITS_KW-1:0] clr_left_in;
    logic [conv_cfg_pkg::BITS_KW-1:0] clr_left;
    logic [conv_cfg_pkg::BITS_KW-1:0] right_code [conv_cfg_pkg::MEMBERS];
    logic                             not_start;

    assign beat_en = aclken && valid_in;
    // columns advance once per cin sweep, or on config
    assign col_en  = beat_en && (user.is_cin_last || user.is_config);
    assign col_end_x = {col_end, 1'b0};

    always_comb begin
        col_end_nxt[1]   = user.is_cols_1_k2 && (user.kw2 != '0);
        // config restarts the row, else the last end column becomes the first start
        col_start_nxt[1] = user.is_config ? (user.kw2 != '0) : col_end_x[user.kw2];
        for (int k = 2; k <= conv_cfg_pkg::KW2_MAX; k++) begin
            col_end_nxt[k]   = col_end[k-1];
            col_start_nxt[k] = user.is_config ? 1'b0 : col_start[k-1];
        end
    end

    // left code from the current start column, kw = 1 and negative codes give center
    for (genvar k2 = 0; k2 <= conv_cfg_pkg::KW2_MAX; k2++) begin : g_left
        localparam int KW = 2 * k2 + 1;
        for (genvar b = 1; b <= conv_cfg_pkg::KW2_MAX; b++) begin : g_bit
            localparam int CODE = 1 + 2 * (b - 1) + KW - conv_cfg_pkg::KW_MAX;
            assign left_lut[k2][b] = (k2 == 0 || CODE < 1) ? '0 : conv_cfg_pkg::BITS_KW'(CODE);
        end
        for (genvar s1 = 0; s1 < conv_cfg_pkg::SW_MAX; s1++) begin : g_shift_b
            // groups of kw+sw-1 members fit into one beat
            localparam int J = KW + s1;
            assign shift_b_lut[k2][s1] = (k2 == 0) ? '0 :
                conv_cfg_pkg::BITS_OUT_SHIFT'(conv_cfg_pkg::MEMBERS / J - 1);
        end
    end

    // right code is 2*log2 of the masked end vector
    for (genvar b = 1; b <= conv_cfg_pkg::KW2_MAX; b++) begin : g_right
        assign right_lut[b] = conv_cfg_pkg::BITS_KW'(2 * b);
    end

    always_comb begin
        clr_left_in = '0;
        for (int b = 1; b <= conv_cfg_pkg::KW2_MAX; b++) begin
            if (col_start[b])
                clr_left_in = left_lut[user.kw2][b];
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            col_start <= '0;
            col_end   <= '0;
            clr_left  <= '0;
        end else if (col_en) begin
            col_start <= col_start_nxt;
            col_end   <= col_end_nxt;
            clr_left  <= clr_left_in;
        end
    end

    for (genvar m = 0; m < conv_cfg_pkg::MEMBERS; m++) begin : g_member
        logic [conv_cfg_pkg::KW2_MAX:0] next_full;

        // member just before the last one of its kernel group
        for (genvar k2 = 0; k2 <= conv_cfg_pkg::KW2_MAX; k2++) begin : g_kern
            localparam int KW = 2 * k2 + 1;
            assign next_full[k2] = ((m % KW) == KW - 2);
        end

        assign masked_en[m] = beat_en && user.is_cin_last && next_full[user.kw2];

        always_ff @(posedge aclk) begin
            if (!rst_n)
                col_end_masked[m] <= '0;
            else if (masked_en[m])
                col_end_masked[m] <= col_end_nxt;
        end

        always_comb begin
            right_code[m] = '0;
            for (int b = 1; b <= conv_cfg_pkg::KW2_MAX; b++) begin
                if (col_end_masked[m][b])
                    right_code[m] = right_lut[b];
            end
        end
    end

    // first kw2 columns of a row carry no full window
    always_comb begin
        not_start = 1'b1;
        for (int b = 1; b <= conv_cfg_pkg::KW2_MAX; b++) begin
            if (b <= int'(user.kw2) && col_start[b])
                not_start = 1'b0;
        end
    end

    always_comb begin
        for (int m = 0; m < conv_cfg_pkg::MEMBERS; m++)
            pad_ctrl.clr[m] = clr_left | right_code[m];
        pad_ctrl.valid_mask = (not_start && user.is_col_valid) || user.is_config;
        pad_ctrl.shift_a    = col_end_x[user.kw2] ?
                              conv_cfg_pkg::BITS_MEMBERS'(user.kw2) : '0;
        pad_ctrl.shift_b    = shift_b_lut[user.kw2][user.sw_1];
    end

    // only one start column may be active
    a_start_onehot: assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(col_start));

    a_kw2_range: assert property (@(posedge aclk) disable iff (!rst_n)
        beat_en |-> (int'(user.kw2) <= conv_cfg_pkg::KW2_MAX));

endmodule

// File: filelist.f
design/conv_cfg_pkg.sv
design/conv_stream_pkg.sv
design/pad_filter.sv
design/member_gate.sv
design/member_shift.sv
design/conv_pad_top.sv
test/conv_pad_checker.sv
test/tb_conv_pad.sv

// File: test/conv_pad_cases.txt
# test cfg colv c1k2 cinl kw2 sw1 valid en | zmask(hex, before rotate) vout rot last_group
# rows with en 0 are stall cycles, their expected columns are not used
1 0 0 0 0 0 0 0 1 00 0 0 0
1 0 0 0 0 0 0 0 1 00 0 0 0
2 1 0 0 0 2 0 1 1 00 1 0 0
2 0 1 0 1 2 0 1 1 00 0 0 0
2 0 1 0 1 2 0 1 1 ff 0 0 0
2 0 1 0 1 2 0 1 1 ff 1 0 0
2 0 1 0 1 2 0 1 1 00 1 0 0
2 0 1 0 1 2 0 1 1 00 1 0 0
2 0 0 0 0 0 0 0 1 00 0 0 0
2 0 0 0 0 0 0 0 1 00 0 0 0
3 0 1 1 1 2 0 1 1 00 1 0 0
3 0 1 0 1 2 0 1 1 08 1 0 0
3 0 1 0 1 2 0 1 1 08 1 2 0
3 0 0 0 0 0 0 0 1 00 0 0 0
3 0 0 0 0 0 0 0 1 00 0 0 0
4 0 1 0 1 1 0 1 1 00 0 0 1
4 0 1 0 1 1 0 1 1 00 1 0 1
4 0 1 0 1 1 0 1 1 ff 1 0 1
4 0 1 1 1 1 0 1 1 00 1 0 1
4 0 1 0 1 1 0 1 1 92 1 1 1
4 1 0 0 1 1 0 1 1 00 1 0 1
4 0 0 0 0 0 0 0 1 00 0 0 0
4 0 0 0 0 0 0 0 1 00 0 0 0
5 0 1 0 1 2 1 1 1 00 0 0 0
5 0 1 0 1 2 1 1 1 ff 0 0 0
5 0 1 0 1 2 1 1 1 ff 1 0 0
5 0 1 0 1 2 1 1 1 00 1 0 0
5 0 1 0 1 2 1 1 1 00 1 0 0
6 0 1 1 1 2 1 1 0 00 0 0 0
6 0 1 1 1 2 1 1 0 00 0 0 0
6 0 1 1 1 2 1 1 1 00 1 0 0
6 0 1 0 1 2 1 1 1 08 1 0 0
6 0 1 0 1 2 1 1 1 08 1 2 0
6 0 0 0 0 0 0 0 1 00 0 0 0
6 0 0 0 0 0 0 0 1 00 0 0 0

// File: test/conv_pad_checker.sv
// conv_pad_checker
// watches beat_out and last_group of the pad stage, rebuilds the expected
// words from the raw data, zero mask and rotate amount, compares the
// user tag, counts errors and prints one line per finished test

`timescale 1ns/100ps

module conv_pad_checker (
    input  logic                                                       aclk,
    input  logic                                                       check_en,
    input  logic                                                       done,
    input  logic [7:0]                                                 check_test,
    input  logic                                                       exp_valid,
    input  logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] exp_raw,
    input  logic [conv_cfg_pkg::MEMBERS-1:0]                           exp_zmask,
    input  logic [conv_cfg_pkg::BITS_MEMBERS-1:0]                      exp_rot,
    input  logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0]                    exp_last_group,
    input  conv_stream_pkg::conv_user_t                                exp_user,
    input  conv_stream_pkg::member_beat_t                              beat_out,
    input  logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0]                    last_group,
    output int                                                         errors,
    output int                                                         checks,
    output int                                                         tests
);

    logic [7:0] cur_test;
    logic       have_test;
    logic       closed;
    int         test_errors;
    int         test_checks;

    // padded members are zeroed first, then output m takes member m+rot
    function automatic logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] expect_data(
        input logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] raw,
        input logic [conv_cfg_pkg::MEMBERS-1:0]                           zmask,
        input logic [conv_cfg_pkg::BITS_MEMBERS-1:0]                      rot
    );
        logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] res;
        int src;
        for (int m = 0; m < conv_cfg_pkg::MEMBERS; m++) begin
            src = (m + int'(rot)) % conv_cfg_pkg::MEMBERS;
            res[m] = zmask[src] ? '0 : raw[src];
        end
        return res;
    endfunction

    task automatic close_test();
        tests = tests + 1;
        if (test_errors == 0)
            $display("test %0d: %0d checks, ok", cur_test, test_checks);
        else
            $display("test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic flag_error(input string name, input logic [127:0] got, input logic [127:0] exp);
        $display("** Error test %0d: %s = %h, expected %h", check_test, name, got, exp);
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    initial begin
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        test_checks = 0;
        cur_test    = '0;
        have_test   = 1'b0;
        closed      = 1'b0;
    end

    // outputs only move on the rising edge, so the falling edge sees them settled
    always @(negedge aclk) begin
        if (check_en && !closed) begin
            if (have_test && check_test != cur_test)
                close_test();
            cur_test  = check_test;
            have_test = 1'b1;

            if (beat_out.valid !== exp_valid)
                flag_error("beat_out.valid", 128'(beat_out.valid), 128'(exp_valid));
            // data only means something on a valid beat
            if (exp_valid && beat_out.data !== expect_data(exp_raw, exp_zmask, exp_rot))
                flag_error("beat_out.data", 128'(beat_out.data),
                           128'(expect_data(exp_raw, exp_zmask, exp_rot)));
            // tag rides along unchanged with its beat
            if (exp_valid && beat_out.user !== exp_user)
                flag_error("beat_out.user", 128'(beat_out.user), 128'(exp_user));
            if (last_group !== exp_last_group)
                flag_error("last_group", 128'(last_group), 128'(exp_last_group));
            checks      = checks + 1;
            test_checks = test_checks + 1;

            if (done) begin
                close_test();
                closed = 1'b1;
            end
        end
    end

endmodule

// File: test/tb_conv_pad.sv
// tb_conv_pad
// clock and reset, reads the cases file, drives beats on the falling edge,
// keeps a two stage expected pipeline, timeout watchdog and summary

`timescale 1ns/100ps

module tb_conv_pad;

    // one row of the cases file
    typedef struct packed {
        logic [7:0]                            test;
        logic                                  cfg;
        logic                                  colv;
        logic                                  c1k2;
        logic                                  cinl;
        logic [conv_cfg_pkg::BITS_KW2-1:0]     kw2;
        logic [conv_cfg_pkg::BITS_SW-1:0]      sw1;
        logic                                  valid;
        logic                                  en;
        logic [conv_cfg_pkg::MEMBERS-1:0]      zmask;
        logic                                  vout;
        logic [conv_cfg_pkg::BITS_MEMBERS-1:0] rot;
        logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] lg;
    } case_row_t;

    // what a beat should look like when it leaves the DUT
    typedef struct packed {
        logic [7:0]                                                 test;
        logic                                                       valid;
        logic [conv_cfg_pkg::MEMBERS-1:0][conv_cfg_pkg::WORD_W-1:0] raw;
        logic [conv_cfg_pkg::MEMBERS-1:0]                           zmask;
        logic [conv_cfg_pkg::BITS_MEMBERS-1:0]                      rot;
        logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0]                    lg;
        conv_stream_pkg::conv_user_t                                user;
    } exp_rec_t;

    logic                                    aclk;
    logic                                    aclken;
    logic                                    rst_n;
    conv_stream_pkg::member_beat_t           beat_in;
    conv_stream_pkg::member_beat_t           beat_out;
    logic [conv_cfg_pkg::BITS_OUT_SHIFT-1:0] last_group;

    case_row_t rows [$];
    exp_rec_t  cur;
    exp_rec_t  mid;
    exp_rec_t  head;
    logic      run;
    logic      done;
    logic      check_en;
    logic [7:0] check_test;
    int        seed;
    int        cycles;
    int        limit;
    logic      limit_ready;
    int        errors;
    int        checks;
    int        tests;

    conv_pad_top u_dut (
        .aclk       (aclk),
        .aclken     (aclken),
        .rst_n      (rst_n),
        .beat_in    (beat_in),
        .beat_out   (beat_out),
        .last_group (last_group)
    );

    conv_pad_checker u_chk (
        .aclk           (aclk),
        .check_en       (check_en),
        .done           (done),
        .check_test     (check_test),
        .exp_valid      (head.valid),
        .exp_raw        (head.raw),
        .exp_zmask      (head.zmask),
        .exp_rot        (head.rot),
        .exp_last_group (head.lg),
        .exp_user       (head.user),
        .beat_out       (beat_out),
        .last_group     (last_group),
        .errors         (errors),
        .checks         (checks),
        .tests          (tests)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    task automatic read_cases();
        int        fd;
        int        n;
        string     line;
        int        t, cfg, colv, c1k2, cinl, kw2, sw1, vld, en, zm, vo, rot, lg;
        case_row_t r;
        fd = $fopen("test/conv_pad_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open test/conv_pad_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // skip comment and blank lines
                if (line.len() > 1 && line.getc(0) != 8'h23) begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %h %d %d %d",
                                t, cfg, colv, c1k2, cinl, kw2, sw1, vld, en, zm, vo, rot, lg);
                    if (n == 13) begin
                        r.test  = 8'(t);
                        r.cfg   = 1'(cfg);
                        r.colv  = 1'(colv);
                        r.c1k2  = 1'(c1k2);
                        r.cinl  = 1'(cinl);
                        r.kw2   = conv_cfg_pkg::BITS_KW2'(kw2);
                        r.sw1   = conv_cfg_pkg::BITS_SW'(sw1);
                        r.valid = 1'(vld);
                        r.en    = 1'(en);
                        r.zmask = conv_cfg_pkg::MEMBERS'(zm);
                        r.vout  = 1'(vo);
                        r.rot   = conv_cfg_pkg::BITS_MEMBERS'(rot);
                        r.lg    = conv_cfg_pkg::BITS_OUT_SHIFT'(lg);
                        rows.push_back(r);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // called on the falling edge, new data words for every row
    task automatic drive_row(input case_row_t r);
        beat_in.valid             = r.valid;
        beat_in.user.is_config    = r.cfg;
        beat_in.user.is_col_valid = r.colv;
        beat_in.user.is_cols_1_k2 = r.c1k2;
        beat_in.user.is_cin_last  = r.cinl;
        beat_in.user.kw2          = r.kw2;
        beat_in.user.sw_1         = r.sw1;
        for (int m = 0; m < conv_cfg_pkg::MEMBERS; m++)
            beat_in.data[m] = conv_cfg_pkg::WORD_W'($random(seed));
        aclken    = r.en;
        cur.test  = r.test;
        cur.valid = r.vout;
        cur.raw   = beat_in.data;
        cur.zmask = r.zmask;
        cur.rot   = r.rot;
        cur.lg    = r.lg;
        cur.user  = beat_in.user;
    endtask

    // expected records move with the DUT, two enabled edges deep
    always @(posedge aclk) begin
        if (run) begin
            check_en <= 1'b1;
            if (aclken) begin
                check_test <= mid.test;
                head       <= mid;
                mid        <= cur;
            end
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
    end

    initial begin
        wait (limit_ready && cycles >= limit);
        $display("timeout, run did not finish within %0d cycles", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        aclken      = 1'b0;
        beat_in     = '0;
        run         = 1'b0;
        done        = 1'b0;
        check_en    = 1'b0;
        check_test  = '0;
        cur         = '0;
        mid         = '0;
        head        = '0;
        cycles      = 0;
        limit       = 0;
        limit_ready = 1'b0;
        seed        = 32'h695c_5091;
        read_cases();
        limit       = rows.size() * 4 + 20;
        limit_ready = 1'b1;
        if (rows.size() == 0) begin
            $display("no test rows were read");
            $display("TB FAILED");
            $finish;
        end else begin
            // reset state checks belong to the first test
            check_test = rows[0].test;
            mid.test   = rows[0].test;
            repeat (2) @(posedge aclk);
            foreach (rows[i]) begin
                @(negedge aclk);
                rst_n = 1'b1;
                drive_row(rows[i]);
                run = 1'b1;
            end
            // hold the pipeline while the checker closes the last test
            @(negedge aclk);
            aclken        = 1'b0;
            beat_in.valid = 1'b0;
            @(posedge aclk);
            done = 1'b1;
            @(negedge aclk);
            @(posedge aclk);
            $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
            if (errors == 0 && checks > 0)
                $display("TB PASSED");
            else
                $display("TB FAILED");
            $finish;
        end
    end

endmodule
